//--- common/exec_pkg.sv
package exec_pkg;

    ////////////////////////////////////////
    // Architectural width
    ////////////////////////////////////////

    localparam int XLEN = 32;

    ////////////////////////////////////////
    // Unit selector
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ADDER_UNIT  = 3'd0,
        LOGIC_UNIT  = 3'd1,
        SHIFT_UNIT  = 3'd2,
        BRANCH_UNIT = 3'd3,
        MUL_UNIT    = 3'd4,
        BYPASS_UNIT = 3'd5
    } exec_unit_e;

    // Operation within a unit, meaning set by the unit selector
    typedef logic [2:0] unit_op_e;

    localparam unit_op_e ADD   = 3'd0;  // Adder unit
    localparam unit_op_e SUB   = 3'd1;
    localparam unit_op_e SLT   = 3'd2;
    localparam unit_op_e SLTU  = 3'd3;

    localparam unit_op_e XOR   = 3'd0;  // Logic unit
    localparam unit_op_e OR    = 3'd1;
    localparam unit_op_e AND   = 3'd2;

    localparam unit_op_e SLL   = 3'd0;  // Shift unit
    localparam unit_op_e SRL   = 3'd1;
    localparam unit_op_e SRA   = 3'd2;

    localparam unit_op_e BEQ   = 3'd0;  // Branch unit
    localparam unit_op_e BNE   = 3'd1;
    localparam unit_op_e BLT   = 3'd2;
    localparam unit_op_e BGE   = 3'd3;
    localparam unit_op_e BLTU  = 3'd4;
    localparam unit_op_e BGEU  = 3'd5;
    localparam unit_op_e JAL   = 3'd6;
    localparam unit_op_e JALR  = 3'd7;

    localparam unit_op_e MUL   = 3'd0;  // Multiplier
    localparam unit_op_e MULHU = 3'd1;

    // Issued operation word, selector in the upper field
    typedef struct packed {
        exec_unit_e unit;
        unit_op_e   op;
    } op_word_t;

endpackage

//--- common/stage_pkg.sv
package stage_pkg;

    ////////////////////////////////////////
    // Issue bundle, producer to execute
    ////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        exec_pkg::op_word_t        op;
        logic [exec_pkg::XLEN-1:0] pc;
        logic [exec_pkg::XLEN-1:0] rs1;
        logic [exec_pkg::XLEN-1:0] rs2;
        logic [exec_pkg::XLEN-1:0] offset;  // Immediate for branches and jumps
        logic [2:0]                tag;
    } issue_t;

    ////////////////////////////////////////
    // Retire bundle, execute to retirement
    ////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        logic [2:0]                tag;
        logic [exec_pkg::XLEN-1:0] result;
        logic [exec_pkg::XLEN-1:0] target;  // Zero unless a branch or jump
        logic                      jump;
        logic                      write_enable;
    } retire_t;

endpackage

//--- hdl/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic [exec_pkg::XLEN-1:0] rs1_i,
    input  logic [exec_pkg::XLEN-1:0] rs2_i,
    input  exec_pkg::exec_unit_e      unit_i,
    input  exec_pkg::unit_op_e        op_i,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    localparam int SHW = $clog2(exec_pkg::XLEN);

    logic [exec_pkg::XLEN-1:0] add_res;
    logic [exec_pkg::XLEN-1:0] logic_res;
    logic [exec_pkg::XLEN-1:0] shift_res;
    logic [SHW-1:0]            shamt;
    logic                      lt_signed;
    logic                      lt_unsigned;

    assign shamt       = rs2_i[SHW-1:0];  // Low bits of rs2 only
    assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_unsigned = rs1_i < rs2_i;

    always_comb begin
        case (op_i)
            exec_pkg::SUB:  add_res = rs1_i - rs2_i;
            exec_pkg::SLT:  add_res = {{(exec_pkg::XLEN-1){1'b0}}, lt_signed};
            exec_pkg::SLTU: add_res = {{(exec_pkg::XLEN-1){1'b0}}, lt_unsigned};
            default:        add_res = rs1_i + rs2_i;
        endcase
    end

    always_comb begin
        case (op_i)
            exec_pkg::OR:  logic_res = rs1_i | rs2_i;
            exec_pkg::AND: logic_res = rs1_i & rs2_i;
            default:       logic_res = rs1_i ^ rs2_i;
        endcase
    end

    always_comb begin
        case (op_i)
            exec_pkg::SRL: shift_res = rs1_i >> shamt;
            exec_pkg::SRA: shift_res = $unsigned($signed(rs1_i) >>> shamt);  // Sign fill
            default:       shift_res = rs1_i << shamt;
        endcase
    end

    // Pick the result of the addressed sub-unit
    always_comb begin
        case (unit_i)
            exec_pkg::LOGIC_UNIT: result_o = logic_res;
            exec_pkg::SHIFT_UNIT: result_o = shift_res;
            default:              result_o = add_res;
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic [exec_pkg::XLEN-1:0] rs1_i,
    input  logic [exec_pkg::XLEN-1:0] rs2_i,
    input  logic [exec_pkg::XLEN-1:0] offset_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    input  exec_pkg::unit_op_e        op_i,
    output logic [exec_pkg::XLEN-1:0] link_o,
    output logic [exec_pkg::XLEN-1:0] target_o,
    output logic                      jump_o,
    output logic                      write_enable_o
);

    logic                      equal;
    logic                      lt_signed;
    logic                      lt_unsigned;
    logic [exec_pkg::XLEN-1:0] jalr_sum;

    assign equal       = rs1_i == rs2_i;
    assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_unsigned = rs1_i < rs2_i;
    assign jalr_sum    = rs1_i + offset_i;

    assign link_o = pc_i + exec_pkg::XLEN'(4);  // Return address

    // JALR clears bit 0 of the register based target
    assign target_o = (op_i == exec_pkg::JALR) ?
                      {jalr_sum[exec_pkg::XLEN-1:1], 1'b0} : pc_i + offset_i;

    always_comb begin
        write_enable_o = 1'b0;  // Conditional branches write nothing
        case (op_i)
            exec_pkg::BEQ:  jump_o = equal;
            exec_pkg::BNE:  jump_o = !equal;
            exec_pkg::BLT:  jump_o = lt_signed;
            exec_pkg::BGE:  jump_o = !lt_signed;
            exec_pkg::BLTU: jump_o = lt_unsigned;
            exec_pkg::BGEU: jump_o = !lt_unsigned;
            default: begin  // JAL and JALR
                jump_o         = 1'b1;
                write_enable_o = 1'b1;
            end
        endcase
    end

endmodule

//--- mul/mul_ctrl.sv
`timescale 1ns/1ps

module mul_ctrl (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic last_step_i,
    input  logic stall_i,
    output logic load_o,
    output logic step_o,
    output logic count_clear_o,
    output logic busy_o,
    output logic done_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e state;
    state_e next_state;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (start_i) next_state = RUN;
            RUN:     if (last_step_i) next_state = DONE;
            DONE:    if (!stall_i) next_state = IDLE;  // Result taken downstream
            default: next_state = IDLE;
        endcase
    end

    assign load_o        = (state == IDLE) && start_i;  // Operands captured on acceptance
    assign count_clear_o = (state == IDLE) && start_i;
    assign step_o        = state == RUN;
    assign busy_o        = state != IDLE;
    assign done_o        = state == DONE;

endmodule

//--- mul/mul_counter.sv
`timescale 1ns/1ps

module mul_counter (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clear_i,
    input  logic enable_i,
    output logic last_step_o
);

    localparam int CW = $clog2(exec_pkg::XLEN);

    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= '0;
        end else if (clear_i) begin
            count <= '0;
        end else if (enable_i) begin
            count <= count + 1'b1;  // Wraps back to zero after the last step
        end
    end

    // High during the final enabled cycle
    assign last_step_o = enable_i && (count == CW'(exec_pkg::XLEN - 1));

endmodule

//--- mul/mul_datapath.sv
`timescale 1ns/1ps

module mul_datapath (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        load_i,
    input  logic                        step_i,
    input  logic [exec_pkg::XLEN-1:0]   multiplicand_i,
    input  logic [exec_pkg::XLEN-1:0]   multiplier_i,
    output logic [2*exec_pkg::XLEN-1:0] product_o
);

    logic [exec_pkg::XLEN-1:0] mcand;
    logic [exec_pkg::XLEN-1:0] acc;    // Upper product half
    logic [exec_pkg::XLEN-1:0] mplier; // Lower half, shifted out as product bits fill in
    logic [exec_pkg::XLEN:0]   sum;

    // Add the multiplicand when the current multiplier bit is set
    assign sum = {1'b0, acc} + (mplier[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mcand  <= '0;
            acc    <= '0;
            mplier <= '0;
        end else if (load_i) begin
            mcand  <= multiplicand_i;
            acc    <= '0;
            mplier <= multiplier_i;
        end else if (step_i) begin
            acc    <= sum[exec_pkg::XLEN:1];  // Shift right with carry
            mplier <= {sum[0], mplier[exec_pkg::XLEN-1:1]};
        end
    end

    assign product_o = {acc, mplier};

endmodule

//--- hdl/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic              clk,
    input  logic              rst_n_i,
    input  stage_pkg::issue_t issue_i,
    input  logic              stall_i,
    output logic              busy_o,
    output stage_pkg::retire_t retire_o
);

    exec_pkg::exec_unit_e        unit_sel;
    exec_pkg::unit_op_e          unit_op;
    logic                        accept;
    logic                        mul_start;
    logic [exec_pkg::XLEN-1:0]   alu_result;
    logic [exec_pkg::XLEN-1:0]   link;
    logic [exec_pkg::XLEN-1:0]   target;
    logic                        jump;
    logic                        branch_we;
    logic                        mul_load;
    logic                        mul_step;
    logic                        mul_clear;
    logic                        mul_done;
    logic                        last_step;
    logic [2*exec_pkg::XLEN-1:0] product;
    logic [2:0]                  mul_tag;
    logic                        mul_high;  // MULHU selects the upper word
    stage_pkg::retire_t          retire_next;

    assign unit_sel  = issue_i.op.unit;
    assign unit_op   = issue_i.op.op;
    assign accept    = issue_i.valid && !stall_i && !busy_o;
    assign mul_start = accept && (unit_sel == exec_pkg::MUL_UNIT);

    ////////////////////////////////////////
    // Execution units
    ////////////////////////////////////////

    int_alu i_alu (
        .rs1_i    (issue_i.rs1),
        .rs2_i    (issue_i.rs2),
        .unit_i   (unit_sel),
        .op_i     (unit_op),
        .result_o (alu_result)
    );

    branch_unit i_branch (
        .rs1_i          (issue_i.rs1),
        .rs2_i          (issue_i.rs2),
        .offset_i       (issue_i.offset),
        .pc_i           (issue_i.pc),
        .op_i           (unit_op),
        .link_o         (link),
        .target_o       (target),
        .jump_o         (jump),
        .write_enable_o (branch_we)
    );

    mul_ctrl i_mul_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (mul_start),
        .last_step_i   (last_step),
        .stall_i       (stall_i),
        .load_o        (mul_load),
        .step_o        (mul_step),
        .count_clear_o (mul_clear),
        .busy_o        (busy_o),
        .done_o        (mul_done)
    );

    mul_counter i_mul_counter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .clear_i     (mul_clear),
        .enable_i    (mul_step),
        .last_step_o (last_step)
    );

    mul_datapath i_mul_datapath (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .load_i         (mul_load),
        .step_i         (mul_step),
        .multiplicand_i (issue_i.rs1),
        .multiplier_i   (issue_i.rs2),
        .product_o      (product)
    );

    // Multiply context kept for the hand-off
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_tag  <= '0;
            mul_high <= 1'b0;
        end else if (mul_start) begin
            mul_tag  <= issue_i.tag;
            mul_high <= unit_op == exec_pkg::MULHU;
        end
    end

    ////////////////////////////////////////
    // Retire demux
    ////////////////////////////////////////

    always_comb begin
        retire_next = '0;  // Bubble unless something retires
        if (mul_done) begin
            retire_next.valid        = 1'b1;
            retire_next.tag          = mul_tag;
            retire_next.result       = mul_high ? product[2*exec_pkg::XLEN-1:exec_pkg::XLEN]
                                                : product[exec_pkg::XLEN-1:0];
            retire_next.write_enable = 1'b1;
        end else if (accept && (unit_sel != exec_pkg::MUL_UNIT)) begin
            retire_next.valid = 1'b1;
            retire_next.tag   = issue_i.tag;
            case (unit_sel)
                exec_pkg::ADDER_UNIT, exec_pkg::LOGIC_UNIT, exec_pkg::SHIFT_UNIT: begin
                    retire_next.result       = alu_result;
                    retire_next.write_enable = 1'b1;
                end
                exec_pkg::BRANCH_UNIT: begin
                    retire_next.result       = link;
                    retire_next.target       = target;
                    retire_next.jump         = jump;
                    retire_next.write_enable = branch_we;
                end
                default: begin  // Bypass passes rs2
                    retire_next.result       = issue_i.rs2;
                    retire_next.write_enable = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_o <= '0;
        end else if (!stall_i) begin
            retire_o <= retire_next;  // Frozen while stalled
        end
    end

endmodule

//--- bench/execute_chk.sv
`timescale 1ns/1ps

module execute_chk (
    input logic               clk,
    input logic               rst_n_i,
    input logic               stall_i,
    input logic               busy_i,
    input stage_pkg::retire_t retire_i
);

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Multiplier in flight leaves only bubbles behind
    property no_retire_while_busy;
        @(posedge clk) disable iff (!rst_n_i) busy_i |-> !retire_i.valid;
    endproperty
    assert property (no_retire_while_busy) else $error("Retire valid while busy");

    property stable_under_stall;
        @(posedge clk) disable iff (!rst_n_i) stall_i |=> $stable(retire_i);
    endproperty
    assert property (stable_under_stall) else $error("Retire output changed under stall");

    property quiet_in_reset;
        @(posedge clk) !rst_n_i |=> !retire_i.valid && !busy_i;
    endproperty
    assert property (quiet_in_reset) else $error("Valid or busy seen during reset");

endmodule

//--- bench/execute_tb.sv
`timescale 1ns/1ps

module execute_tb;

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 200;  // Multiply length plus stall slack
    localparam int MUL_LATENCY    = 34;  // Acceptance to product on retire_o without stall

    logic               clk;
    logic               rst_n;
    stage_pkg::issue_t  issue;
    logic               stall;
    logic               busy;
    stage_pkg::retire_t retire;

    integer             seed;
    int                 errors;
    int                 checks;
    int                 accepted;
    int                 retired;
    int                 cycles;
    int                 mul_age;      // Clocks since the pending multiply was accepted
    logic               mul_pending;  // Multiply accepted, product not yet retired
    logic               alu_due;      // Single cycle result expected at next sample
    logic               prev_stall;
    stage_pkg::retire_t last_retire;
    stage_pkg::issue_t  pending_q[$];

    execute i_dut (
        .clk      (clk),
        .rst_n_i  (rst_n),
        .issue_i  (issue),
        .stall_i  (stall),
        .busy_o   (busy),
        .retire_o (retire)
    );

    bind execute execute_chk i_chk (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .busy_i   (busy_o),
        .retire_i (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [69:0] expected,
                               input logic [69:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic logic [31:0] pick_operand();
        case ($unsigned($random(seed)) % 8)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hFFFF_FFFF;
            3:       return 32'h8000_0000;  // Signed boundaries
            4:       return 32'h7FFF_FFFF;
            default: return $random(seed);
        endcase
    endfunction

    task automatic make_instruction(output stage_pkg::issue_t ins);
        int pick;
        int span;
        ins        = '0;
        ins.valid  = ($random(seed) & 7) != 0;  // Occasional empty slot
        ins.pc     = $random(seed) & 32'hFFFF_FFFC;
        ins.rs1    = pick_operand();
        ins.rs2    = (($random(seed) & 3) == 0) ? ins.rs1 : pick_operand();
        ins.offset = $random(seed);
        ins.tag    = accepted[2:0];
        pick       = $unsigned($random(seed)) % 12;
        if (pick < 2) begin
            ins.op.unit = exec_pkg::ADDER_UNIT;
            span        = 4;
        end else if (pick < 4) begin
            ins.op.unit = exec_pkg::LOGIC_UNIT;
            span        = 3;
        end else if (pick < 6) begin
            ins.op.unit = exec_pkg::SHIFT_UNIT;
            span        = 3;
        end else if (pick < 9) begin
            ins.op.unit = exec_pkg::BRANCH_UNIT;
            span        = 8;
        end else if (pick < 10) begin
            ins.op.unit = exec_pkg::MUL_UNIT;
            span        = 2;
        end else begin
            ins.op.unit = exec_pkg::BYPASS_UNIT;
            span        = 8;
        end
        ins.op.op = 3'($unsigned($random(seed)) % span);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic stage_pkg::retire_t model_retire(input stage_pkg::issue_t ins);
        stage_pkg::retire_t r;
        logic [63:0]        prod;
        r              = '0;
        r.valid        = 1'b1;
        r.tag          = ins.tag;
        r.write_enable = 1'b1;
        prod           = {32'h0, ins.rs1} * {32'h0, ins.rs2};
        case (ins.op.unit)
            exec_pkg::ADDER_UNIT: begin
                case (ins.op.op)
                    exec_pkg::SUB:  r.result = ins.rs1 - ins.rs2;
                    exec_pkg::SLT:  r.result = {31'h0, $signed(ins.rs1) < $signed(ins.rs2)};
                    exec_pkg::SLTU: r.result = {31'h0, ins.rs1 < ins.rs2};
                    default:        r.result = ins.rs1 + ins.rs2;
                endcase
            end
            exec_pkg::LOGIC_UNIT: begin
                case (ins.op.op)
                    exec_pkg::OR:  r.result = ins.rs1 | ins.rs2;
                    exec_pkg::AND: r.result = ins.rs1 & ins.rs2;
                    default:       r.result = ins.rs1 ^ ins.rs2;
                endcase
            end
            exec_pkg::SHIFT_UNIT: begin
                case (ins.op.op)
                    exec_pkg::SRL: r.result = ins.rs1 >> ins.rs2[4:0];
                    exec_pkg::SRA: r.result = $signed(ins.rs1) >>> ins.rs2[4:0];
                    default:       r.result = ins.rs1 << ins.rs2[4:0];
                endcase
            end
            exec_pkg::BRANCH_UNIT: begin
                r.result       = ins.pc + 32'd4;  // Link address
                r.target       = ins.pc + ins.offset;
                r.write_enable = 1'b0;
                case (ins.op.op)
                    exec_pkg::BEQ:  r.jump = ins.rs1 == ins.rs2;
                    exec_pkg::BNE:  r.jump = ins.rs1 != ins.rs2;
                    exec_pkg::BLT:  r.jump = $signed(ins.rs1) < $signed(ins.rs2);
                    exec_pkg::BGE:  r.jump = $signed(ins.rs1) >= $signed(ins.rs2);
                    exec_pkg::BLTU: r.jump = ins.rs1 < ins.rs2;
                    exec_pkg::BGEU: r.jump = ins.rs1 >= ins.rs2;
                    default: begin
                        r.jump         = 1'b1;
                        r.write_enable = 1'b1;
                        if (ins.op.op == exec_pkg::JALR) begin
                            r.target = (ins.rs1 + ins.offset) & 32'hFFFF_FFFE;
                        end
                    end
                endcase
            end
            exec_pkg::MUL_UNIT: r.result = (ins.op.op == exec_pkg::MULHU) ? prod[63:32]
                                                                          : prod[31:0];
            default:            r.result = ins.rs2;  // Bypass
        endcase
        return r;
    endfunction

    ////////////////////////////////////////
    // Per cycle drive and compare
    ////////////////////////////////////////

    task automatic drive_cycle();
        stage_pkg::issue_t ins;
        stall = ($random(seed) & 3) == 0;
        if (!busy) begin  // Issue is held while busy
            make_instruction(ins);
            issue = ins;
            if (accepted >= NUM_INSTR) begin
                issue.valid = 1'b0;
            end
        end
        alu_due = 1'b0;
        if (issue.valid && !stall && !busy) begin
            pending_q.push_back(issue);
            accepted++;
            if (issue.op.unit == exec_pkg::MUL_UNIT) begin
                mul_pending = 1'b1;
                mul_age     = 0;
            end else begin
                alu_due = 1'b1;
            end
        end
        prev_stall = stall;
    endtask

    task automatic check_cycle();
        stage_pkg::issue_t ins;
        logic              valid_due;
        if (mul_pending) begin
            mul_age++;
        end
        if (prev_stall) begin
            check_value("hold under stall", last_retire, retire);
        end else begin
            // Bubble unless a single cycle result or a finished product is due
            valid_due = alu_due || (mul_pending && mul_age >= MUL_LATENCY);
            check_value("retire valid", 70'(valid_due), 70'(retire.valid));
            if (retire.valid) begin
                if (pending_q.size() == 0) begin
                    errors++;
                    $display("Unexpected retire of tag %0d with no instruction outstanding",
                             retire.tag);
                end else begin
                    ins = pending_q.pop_front();
                    check_value($sformatf("retire unit %0d op %0d tag %0d", ins.op.unit,
                                          ins.op.op, ins.tag), model_retire(ins), retire);
                    retired++;
                    if (ins.op.unit == exec_pkg::MUL_UNIT) begin
                        mul_pending = 1'b0;
                    end
                end
            end
        end
        check_value("busy", 70'(mul_pending), 70'(busy));
        last_retire = retire;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d instructions still outstanding",
                 cycles, pending_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed        = 63529;
        errors      = 0;
        checks      = 0;
        accepted    = 0;
        retired     = 0;
        mul_age     = 0;
        mul_pending = 1'b0;
        alu_due     = 1'b0;
        prev_stall  = 1'b0;
        issue       = '0;
        stall       = 1'b0;
        rst_n       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("retire after reset", '0, retire);
        check_value("busy after reset", 70'(0), 70'(busy));
        last_retire = retire;
        while (accepted < NUM_INSTR || pending_q.size() != 0) begin
            drive_cycle();
            @(negedge clk);  // Outputs settled since the rising edge
            check_cycle();
        end
        $display("Summary: %0d checks, %0d errors, %0d of %0d instructions retired",
                 checks, errors, retired, accepted);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
common/exec_pkg.sv
common/stage_pkg.sv
hdl/int_alu.sv
hdl/branch_unit.sv
mul/mul_ctrl.sv
mul/mul_counter.sv
mul/mul_datapath.sv
hdl/execute.sv
bench/execute_chk.sv
bench/execute_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module execute_tb -f all.f -o execute_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/execute_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
